// ==== common/spi_periph_pkg.sv ====
`default_nettype none

package spi_periph_pkg;

  typedef struct packed {
    logic        req;
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  wr_mask;
    logic [3:0]  rd_mask;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] data;
  } bus_rsp_t;

  typedef struct packed {
    logic cs_n;
    logic mosi;
    logic dc;
  } spi_drive_t;

  typedef struct packed {
    logic sck;
    logic cs_n;
    logic mosi;
    logic dc;
  } spi_pins_t;

  // Pin levels while nobody holds the bus
  localparam spi_drive_t SPI_IDLE = '{cs_n: 1'b1, mosi: 1'b1, dc: 1'b0};

  localparam int SPI_DIV       = 8;
  localparam int SPI_DIV_W     = $clog2(SPI_DIV);
  localparam int SD_FRAME_BITS = 48;
  localparam int R1_BITS       = 8;
  localparam int R7_BITS       = 40;
  localparam int CMD_IF_COND   = 8;
  localparam int CMD_READ_OCR  = 58;

  localparam logic [31:0] SD_NOP      = 32'h00;
  localparam logic [31:0] SD_SEND     = 32'h04;
  localparam logic [31:0] SD_CMD_LO   = 32'h08;
  localparam logic [31:0] SD_CMD_HI   = 32'h0C;
  localparam logic [31:0] SD_RSP_FLAG = 32'h10;
  localparam logic [31:0] SD_RSP_LO   = 32'h14;
  localparam logic [31:0] SD_RSP_HI   = 32'h18;

  localparam logic [31:0] LCD_CMD   = 32'h00;
  localparam logic [31:0] LCD_DATA  = 32'h04;
  localparam logic [31:0] LCD_COUNT = 32'h08;

  // Byte-lane merge for register writes
  function automatic logic [31:0] wr_lanes(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  mask);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++)
    begin
      if (mask[i])
        res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  // Lanes not selected read as zero
  function automatic logic [31:0] rd_lanes(input logic [31:0] value,
                                           input logic [3:0]  mask);
    logic [31:0] res;
    res = '0;
    for (int i = 0; i < 4; i++)
    begin
      if (mask[i])
        res[8*i +: 8] = value[8*i +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// ==== sdcard/sd_cmd_ctrl.sv ====
`default_nettype none

module sd_cmd_ctrl (
  input  logic                       clk,
  input  logic                       rst,
  input  spi_periph_pkg::bus_req_t   i_bus,
  output spi_periph_pkg::bus_rsp_t   o_rsp,
  output logic                       o_spi_req,
  input  logic                       i_spi_ack,
  input  logic                       i_tick,
  input  logic                       i_miso,
  output spi_periph_pkg::spi_drive_t o_drive
);
  import spi_periph_pkg::*;

  typedef enum logic [6:0] {
    S_IDLE  = 7'b0000001,
    S_REG   = 7'b0000010,
    S_HOLD  = 7'b0000100,
    S_REQ   = 7'b0001000,
    S_FRAME = 7'b0010000,
    S_START = 7'b0100000,
    S_RESP  = 7'b1000000
  } state_t;

  state_t                   state;
  logic [SD_FRAME_BITS-1:0] frame;
  logic [47:0]              rsp;
  logic                     rsp_flag;
  logic [5:0]               bit_cnt;
  logic [5:0]               cmd_idx;
  logic [5:0]               rsp_len;
  logic [31:0]              bus_addr;
  logic [31:0]              rd_word;
  logic [31:0]              hi_wr;
  logic                     send_wr;

  assign bus_addr = {i_bus.addr[31:2], 2'b00};
  assign send_wr  = i_bus.req && i_bus.write && (bus_addr == SD_SEND);
  assign hi_wr    = wr_lanes({16'h0000, frame[47:32]}, i_bus.data, i_bus.wr_mask);

  // R7-length reply for IF_COND and READ_OCR
  assign cmd_idx = frame[45:40];
  assign rsp_len = (cmd_idx == 6'(CMD_IF_COND) || cmd_idx == 6'(CMD_READ_OCR)) ?
                   6'(R7_BITS) : 6'(R1_BITS);

  always_comb
  begin
    case (bus_addr)
      SD_NOP, SD_SEND: rd_word = '0;
      SD_CMD_LO:       rd_word = frame[31:0];
      SD_CMD_HI:       rd_word = {16'h0000, frame[47:32]};
      SD_RSP_FLAG:     rd_word = {31'd0, rsp_flag};
      SD_RSP_LO:       rd_word = rsp[31:0];
      SD_RSP_HI:       rd_word = {16'h0000, rsp[47:32]};
      default:         rd_word = '0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= S_IDLE;
      rsp_flag  <= 1'b0;
      bit_cnt   <= '0;
      o_rsp     <= '0;
      o_spi_req <= 1'b0;
      o_drive   <= SPI_IDLE;
    end
    else
    begin
      o_rsp <= '0;
      case (state)
        S_IDLE:
        begin
          if (send_wr)
          begin
            rsp_flag <= 1'b0;
            state    <= S_REQ;
          end
          else if (i_bus.req)
            state <= S_REG;
        end
        S_REG:
        begin
          o_rsp.ack  <= 1'b1;
          o_rsp.data <= rd_lanes(rd_word, i_bus.rd_mask);
          state      <= S_HOLD;
        end
        S_HOLD:
        begin
          if (!i_bus.req)
            state <= S_IDLE;
        end
        S_REQ:
        begin
          // Previous grant must be seen released first
          if (!o_spi_req && !i_spi_ack)
            o_spi_req <= 1'b1;
          else if (o_spi_req && i_spi_ack)
          begin
            bit_cnt <= 6'(SD_FRAME_BITS);
            state   <= S_FRAME;
          end
        end
        S_FRAME:
        begin
          if (i_tick)
          begin
            if (bit_cnt == 6'd0)
            begin
              o_drive.mosi <= 1'b1;
              state        <= S_START;
            end
            else
            begin
              o_drive.cs_n <= 1'b0;
              o_drive.mosi <= frame[bit_cnt - 6'd1];
              bit_cnt      <= bit_cnt - 6'd1;
            end
          end
        end
        S_START:
        begin
          // Start bit is the reply MSB, already zero in rsp
          if (i_tick && !i_miso)
          begin
            bit_cnt <= 6'd1;
            state   <= S_RESP;
          end
        end
        S_RESP:
        begin
          if (i_tick)
          begin
            if (bit_cnt == rsp_len - 6'd1)
            begin
              o_drive.cs_n <= 1'b1;
              o_spi_req    <= 1'b0;
              rsp_flag     <= 1'b1;
              o_rsp.ack    <= 1'b1;
              state        <= S_HOLD;
            end
            else
              bit_cnt <= bit_cnt + 6'd1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == S_REG && i_bus.write)
    begin
      if (bus_addr == SD_CMD_LO)
        frame[31:0] <= wr_lanes(frame[31:0], i_bus.data, i_bus.wr_mask);
      if (bus_addr == SD_CMD_HI)
        frame[47:32] <= hi_wr[15:0];
    end
    if (state == S_IDLE && send_wr)
      rsp <= '0;
    else if (state == S_RESP && i_tick)
      rsp <= {rsp[46:0], i_miso};
  end

endmodule

`default_nettype wire

// ==== lcd/lcd_byte_writer.sv ====
`default_nettype none

module lcd_byte_writer (
  input  logic                       clk,
  input  logic                       rst,
  input  spi_periph_pkg::bus_req_t   i_bus,
  output spi_periph_pkg::bus_rsp_t   o_rsp,
  output logic                       o_spi_req,
  input  logic                       i_spi_ack,
  input  logic                       i_tick,
  output spi_periph_pkg::spi_drive_t o_drive
);
  import spi_periph_pkg::*;

  typedef enum logic [2:0] {
    L_IDLE,
    L_REG,
    L_HOLD,
    L_REQ,
    L_SHIFT
  } state_t;

  state_t      state;
  logic [7:0]  tx_byte;
  logic [3:0]  bit_cnt;
  logic [15:0] sent_cnt;
  logic [31:0] bus_addr;
  logic [31:0] rd_word;
  logic        byte_wr;

  assign bus_addr = {i_bus.addr[31:2], 2'b00};
  assign byte_wr  = i_bus.req && i_bus.write &&
                    (bus_addr == LCD_CMD || bus_addr == LCD_DATA);
  assign rd_word  = (bus_addr == LCD_COUNT) ? {16'h0000, sent_cnt} : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= L_IDLE;
      bit_cnt   <= '0;
      sent_cnt  <= '0;
      o_rsp     <= '0;
      o_spi_req <= 1'b0;
      o_drive   <= SPI_IDLE;
    end
    else
    begin
      o_rsp <= '0;
      case (state)
        L_IDLE:
        begin
          if (byte_wr)
          begin
            o_drive.dc <= (bus_addr == LCD_DATA);
            state      <= L_REQ;
          end
          else if (i_bus.req)
            state <= L_REG;
        end
        L_REG:
        begin
          o_rsp.ack  <= 1'b1;
          o_rsp.data <= rd_lanes(rd_word, i_bus.rd_mask);
          state      <= L_HOLD;
        end
        L_HOLD:
        begin
          if (!i_bus.req)
            state <= L_IDLE;
        end
        L_REQ:
        begin
          if (!o_spi_req && !i_spi_ack)
            o_spi_req <= 1'b1;
          else if (o_spi_req && i_spi_ack)
          begin
            bit_cnt <= 4'd8;
            state   <= L_SHIFT;
          end
        end
        L_SHIFT:
        begin
          if (i_tick)
          begin
            if (bit_cnt == 4'd0)
            begin
              o_drive.cs_n <= 1'b1;
              o_drive.mosi <= 1'b1;
              o_spi_req    <= 1'b0;
              sent_cnt     <= sent_cnt + 16'd1;
              o_rsp.ack    <= 1'b1;
              state        <= L_HOLD;
            end
            else
            begin
              o_drive.cs_n <= 1'b0;
              o_drive.mosi <= tx_byte[7];
              bit_cnt      <= bit_cnt - 4'd1;
            end
          end
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  // MSB first
  always_ff @(posedge clk)
  begin
    if (state == L_IDLE && byte_wr)
      tx_byte <= i_bus.data[7:0];
    else if (state == L_SHIFT && i_tick)
      tx_byte <= {tx_byte[6:0], 1'b0};
  end

endmodule

`default_nettype wire

// ==== hw/spi_arbiter.sv ====
`default_nettype none

module spi_arbiter (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_sd_req,
  output logic                       o_sd_ack,
  input  spi_periph_pkg::spi_drive_t i_sd_drive,
  input  logic                       i_lcd_req,
  output logic                       o_lcd_ack,
  input  spi_periph_pkg::spi_drive_t i_lcd_drive,
  output logic                       o_tick,
  output spi_periph_pkg::spi_pins_t  o_pins
);
  import spi_periph_pkg::*;

  logic [SPI_DIV_W-1:0] div_cnt;
  logic                 sck;
  logic                 last_lcd;
  spi_drive_t           drive;

  // Tick lands on count zero, SCK high over the middle half
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      div_cnt <= '0;
      sck     <= 1'b0;
      o_tick  <= 1'b0;
    end
    else
    begin
      if (div_cnt == SPI_DIV_W'(SPI_DIV - 1))
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + SPI_DIV_W'(1);
      o_tick <= (div_cnt == SPI_DIV_W'(SPI_DIV - 1));
      sck    <= (div_cnt >= SPI_DIV_W'(SPI_DIV / 4 - 1)) &&
                (div_cnt <  SPI_DIV_W'(3 * SPI_DIV / 4 - 1));
    end
  end

  // last_lcd flips only on a contested grant; reset favours the SD side
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      o_sd_ack  <= 1'b0;
      o_lcd_ack <= 1'b0;
      last_lcd  <= 1'b1;
    end
    else if (o_sd_ack)
    begin
      if (!i_sd_req)
        o_sd_ack <= 1'b0;
    end
    else if (o_lcd_ack)
    begin
      if (!i_lcd_req)
        o_lcd_ack <= 1'b0;
    end
    else if (i_sd_req && i_lcd_req)
    begin
      o_sd_ack  <= last_lcd;
      o_lcd_ack <= !last_lcd;
      last_lcd  <= !last_lcd;
    end
    else if (i_sd_req)
      o_sd_ack <= 1'b1;
    else if (i_lcd_req)
      o_lcd_ack <= 1'b1;
  end

  always_comb
  begin
    drive = SPI_IDLE;
    if (o_sd_ack)
      drive = i_sd_drive;
    else if (o_lcd_ack)
      drive = i_lcd_drive;
  end

  assign o_pins = '{sck: sck, cs_n: drive.cs_n, mosi: drive.mosi, dc: drive.dc};

endmodule

`default_nettype wire

// ==== hw/spi_periph_top.sv ====
`default_nettype none

module spi_periph_top (
  input  logic                      clk,
  input  logic                      rst,
  input  spi_periph_pkg::bus_req_t  i_sd_bus,
  input  spi_periph_pkg::bus_req_t  i_lcd_bus,
  output spi_periph_pkg::bus_rsp_t  o_sd_rsp,
  output spi_periph_pkg::bus_rsp_t  o_lcd_rsp,
  input  logic                      i_miso,
  output spi_periph_pkg::spi_pins_t o_pins
);
  import spi_periph_pkg::*;

  logic       sd_req;
  logic       sd_ack;
  logic       lcd_req;
  logic       lcd_ack;
  logic       tick;
  spi_drive_t sd_drive;
  spi_drive_t lcd_drive;

  sd_cmd_ctrl u_sd (
    .clk       (clk),
    .rst       (rst),
    .i_bus     (i_sd_bus),
    .o_rsp     (o_sd_rsp),
    .o_spi_req (sd_req),
    .i_spi_ack (sd_ack),
    .i_tick    (tick),
    .i_miso    (i_miso),
    .o_drive   (sd_drive)
  );

  lcd_byte_writer u_lcd (
    .clk       (clk),
    .rst       (rst),
    .i_bus     (i_lcd_bus),
    .o_rsp     (o_lcd_rsp),
    .o_spi_req (lcd_req),
    .i_spi_ack (lcd_ack),
    .i_tick    (tick),
    .o_drive   (lcd_drive)
  );

  spi_arbiter u_arb (
    .clk         (clk),
    .rst         (rst),
    .i_sd_req    (sd_req),
    .o_sd_ack    (sd_ack),
    .i_sd_drive  (sd_drive),
    .i_lcd_req   (lcd_req),
    .o_lcd_ack   (lcd_ack),
    .i_lcd_drive (lcd_drive),
    .o_tick      (tick),
    .o_pins      (o_pins)
  );

endmodule

`default_nettype wire

// ==== sim/spi_arbiter_sva.sv ====
`default_nettype none

module spi_arbiter_sva (
  input logic clk,
  input logic rst,
  input logic i_sd_req,
  input logic o_sd_ack,
  input logic i_lcd_req,
  input logic o_lcd_ack
);

  one_grant: assert property (@(posedge clk) disable iff (rst)
    !(o_sd_ack && o_lcd_ack))
    else $error("both acks high");

  sd_rise_with_req: assert property (@(posedge clk) disable iff (rst)
    $rose(o_sd_ack) |-> i_sd_req)
    else $error("SD ack rose without its request");

  lcd_rise_with_req: assert property (@(posedge clk) disable iff (rst)
    $rose(o_lcd_ack) |-> i_lcd_req)
    else $error("display ack rose without its request");

  sd_hold: assert property (@(posedge clk) disable iff (rst)
    (o_sd_ack && i_sd_req) |=> o_sd_ack)
    else $error("SD ack dropped while request held");

  lcd_hold: assert property (@(posedge clk) disable iff (rst)
    (o_lcd_ack && i_lcd_req) |=> o_lcd_ack)
    else $error("display ack dropped while request held");

endmodule

bind spi_arbiter spi_arbiter_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .i_sd_req  (i_sd_req),
  .o_sd_ack  (o_sd_ack),
  .i_lcd_req (i_lcd_req),
  .o_lcd_ack (o_lcd_ack)
);

`default_nettype wire

// ==== sim/tb_spi_periph.sv ====
`default_nettype none

module tb_spi_periph;
  import spi_periph_pkg::*;

  logic      clk;
  logic      rst;
  logic      miso;
  bus_req_t  sd_bus;
  bus_req_t  lcd_bus;
  bus_rsp_t  sd_rsp;
  bus_rsp_t  lcd_rsp;
  spi_pins_t pins;

  // Card and display models
  logic [47:0] shreg;
  logic [47:0] sd_frame;
  logic [39:0] sd_reply;
  logic        last_dc;
  int          nbits = 0;
  int          rbit = 0;
  int          rlen = 8;
  logic [48:0] sd_q[$];
  logic [48:0] lcd_q[$];
  logic        order_q[$];

  int tests = 0;
  int checks = 0;
  int errors = 0;
  int lcd_sent = 0;

  spi_periph_top uut (
    .clk       (clk),
    .rst       (rst),
    .i_sd_bus  (sd_bus),
    .i_lcd_bus (lcd_bus),
    .o_sd_rsp  (sd_rsp),
    .o_lcd_rsp (lcd_rsp),
    .i_miso    (miso),
    .o_pins    (pins)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge pins.sck)
  begin
    if (!pins.cs_n)
    begin
      shreg   = {shreg[46:0], pins.mosi};
      last_dc = pins.dc;
      nbits++;
      if (nbits == 48)
      begin
        sd_frame = shreg;
        // IF_COND and READ_OCR answer with 40 bits
        rlen = (shreg[45:40] == 6'd8 || shreg[45:40] == 6'd58) ? 40 : 8;
      end
    end
  end

  // Three idle bits, then the reply MSB first
  always @(negedge pins.sck)
  begin
    if (!pins.cs_n && nbits >= 48)
    begin
      if (rbit < 3 || rbit >= rlen + 3)
        miso <= 1'b1;
      else
        miso <= sd_reply[rlen + 2 - rbit];
      rbit++;
    end
  end

  always @(posedge pins.cs_n)
  begin
    if (nbits == 8)
    begin
      lcd_q.push_back({last_dc, 40'd0, shreg[7:0]});
      order_q.push_back(1'b0);
    end
    else if (nbits >= 48)
    begin
      sd_q.push_back({1'b0, sd_frame});
      order_q.push_back(1'b1);
    end
    else if (nbits != 0)
    begin
      errors++;
      $display("Transfer of %0d bits matches neither device", nbits);
    end
    nbits = 0;
    rbit  = 0;
    miso <= 1'b1;
  end

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    $display("TEST RESULT: FAIL");
    $finish;
  endtask

  task automatic compare_rsp(input string name, input logic [31:0] exp, input bus_rsp_t act);
    checks++;
    if (act.data !== exp)
    begin
      errors++;
      $display("Mismatch in %s: expected %08h, actual %08h", name, exp, act.data);
    end
  endtask

  task automatic compare_frame(input string name, input logic [48:0] exp,
                               input logic [48:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Mismatch in %s: expected %013h, actual %013h", name, exp, act);
    end
  endtask

  task automatic bus_xfer(input bit to_lcd, input bit wr, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] wmask,
                          input logic [3:0] rmask, output bus_rsp_t rsp);
    bus_req_t r;
    int       n;
    r = '{req: 1'b1, write: wr, addr: addr, data: data, wr_mask: wmask, rd_mask: rmask};
    @(posedge clk);
    #5;
    if (to_lcd)
      lcd_bus = r;
    else
      sd_bus = r;
    n   = 0;
    rsp = '0;
    while (!rsp.ack)
    begin
      @(negedge clk);
      rsp = to_lcd ? lcd_rsp : sd_rsp;
      n++;
      if (n > 20000)
        abort_run("bus request never acked");
    end
    @(posedge clk);
    #5;
    if (to_lcd)
      lcd_bus = '0;
    else
      sd_bus = '0;
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("%s: %0d errors", name, errors - err_before);
  endtask

  function automatic logic [47:0] make_frame(input logic [5:0] idx);
    logic [31:0] arg;
    logic [7:0]  crc;
    arg = $urandom;
    crc = 8'($urandom) | 8'h01;
    return {2'b01, idx, arg, crc};
  endfunction

  task automatic load_frame(input logic [47:0] f);
    bus_rsp_t r;
    bus_xfer(1'b0, 1'b1, SD_CMD_LO, f[31:0], 4'hF, 4'h0, r);
    bus_xfer(1'b0, 1'b1, SD_CMD_HI, {16'h0000, f[47:32]}, 4'hF, 4'h0, r);
  endtask

  task automatic sd_command(input string name, input logic [5:0] idx,
                            input logic [39:0] reply, input int len);
    logic [47:0] f;
    bus_rsp_t    r;
    int          e;
    e        = errors;
    f        = make_frame(idx);
    sd_reply = reply;
    sd_q.delete();
    load_frame(f);
    bus_xfer(1'b0, 1'b1, SD_SEND, 32'h0, 4'hF, 4'h0, r);
    checks++;
    if (sd_q.size() != 1 || pins.cs_n !== 1'b1)
    begin
      errors++;
      $display("%s: card saw no complete frame or CS stayed low", name);
    end
    else
      compare_frame(name, {1'b0, f}, sd_q.pop_front());
    bus_xfer(1'b0, 1'b0, SD_RSP_LO, 32'h0, 4'h0, 4'hF, r);
    compare_rsp(name, (len == 40) ? reply[31:0] : {24'd0, reply[7:0]}, r);
    bus_xfer(1'b0, 1'b0, SD_RSP_HI, 32'h0, 4'h0, 4'hF, r);
    compare_rsp(name, (len == 40) ? {24'd0, reply[39:32]} : 32'h0, r);
    bus_xfer(1'b0, 1'b0, SD_RSP_FLAG, 32'h0, 4'h0, 4'hF, r);
    compare_rsp(name, 32'h1, r);
    end_test(name, e);
  endtask

  task automatic test_masks();
    bus_rsp_t r;
    int       e;
    e = errors;
    // No reply has arrived yet
    bus_xfer(1'b0, 1'b0, SD_RSP_FLAG, 32'h0, 4'h0, 4'hF, r);
    compare_rsp("masks", 32'h0, r);
    bus_xfer(1'b0, 1'b1, SD_CMD_LO, 32'h11223344, 4'hF, 4'h0, r);
    bus_xfer(1'b0, 1'b1, SD_CMD_LO, 32'hAABBCCDD, 4'b0101, 4'h0, r);
    bus_xfer(1'b0, 1'b0, SD_CMD_LO, 32'h0, 4'h0, 4'hF, r);
    compare_rsp("masks", 32'h11BB33DD, r);
    bus_xfer(1'b0, 1'b0, SD_CMD_LO, 32'h0, 4'h0, 4'b0011, r);
    compare_rsp("masks", 32'h000033DD, r);
    bus_xfer(1'b0, 1'b0, SD_CMD_LO, 32'h0, 4'h0, 4'b1000, r);
    compare_rsp("masks", 32'h11000000, r);
    bus_xfer(1'b0, 1'b1, SD_CMD_HI, 32'h12345678, 4'hF, 4'h0, r);
    bus_xfer(1'b0, 1'b1, SD_CMD_HI, 32'h0000AB00, 4'b0010, 4'h0, r);
    bus_xfer(1'b0, 1'b0, SD_CMD_HI, 32'h0, 4'h0, 4'hF, r);
    compare_rsp("masks", 32'h0000AB78, r);
    bus_xfer(1'b0, 1'b0, 32'h40, 32'h0, 4'h0, 4'hF, r);
    compare_rsp("masks", 32'h0, r);
    end_test("masks", e);
  endtask

  task automatic test_display();
    bus_rsp_t   r;
    logic [7:0] b;
    bit         is_data;
    int         e;
    e = errors;
    for (int i = 0; i < 4; i++)
    begin
      b       = 8'($urandom);
      is_data = (i % 2) == 1;
      lcd_q.delete();
      bus_xfer(1'b1, 1'b1, is_data ? LCD_DATA : LCD_CMD, {24'd0, b}, 4'hF, 4'h0, r);
      lcd_sent++;
      checks++;
      if (lcd_q.size() != 1)
      begin
        errors++;
        $display("display: sink saw %0d bytes for one write", lcd_q.size());
      end
      else
        compare_frame("display", {is_data, 40'd0, b}, lcd_q.pop_front());
    end
    bus_xfer(1'b1, 1'b0, LCD_COUNT, 32'h0, 4'h0, 4'hF, r);
    compare_rsp("display", 32'(lcd_sent), r);
    end_test("display", e);
  endtask

  task automatic test_contention(input string name, input bit sd_first);
    logic [47:0] f;
    logic [7:0]  b;
    bus_rsp_t    rs;
    bus_rsp_t    rl;
    int          e;
    e        = errors;
    f        = make_frame(6'd0);
    b        = 8'($urandom);
    sd_reply = 40'h01;
    load_frame(f);
    sd_q.delete();
    lcd_q.delete();
    order_q.delete();
    fork
      bus_xfer(1'b0, 1'b1, SD_SEND, 32'h0, 4'hF, 4'h0, rs);
      bus_xfer(1'b1, 1'b1, LCD_DATA, {24'd0, b}, 4'hF, 4'h0, rl);
    join
    lcd_sent++;
    checks++;
    if (sd_q.size() != 1 || lcd_q.size() != 1 || order_q.size() != 2)
    begin
      errors++;
      $display("%s: expected one card frame and one display byte", name);
    end
    else
    begin
      compare_frame(name, {1'b0, f}, sd_q.pop_front());
      compare_frame(name, {1'b1, 40'd0, b}, lcd_q.pop_front());
      checks++;
      if (order_q[0] != sd_first)
      begin
        errors++;
        $display("%s: wrong client was granted the pins first", name);
      end
    end
    end_test(name, e);
  endtask

  initial
  begin
    void'($urandom(32'he864_8b3a));
    rst     = 1'b1;
    miso   <= 1'b1;
    sd_bus  = '0;
    lcd_bus = '0;
    repeat (16) @(posedge clk);
    #5;
    rst = 1'b0;

    test_masks();
    sd_command("r1_command", 6'd0, 40'h01, 8);
    // Reply MSB is the start bit and must be zero
    sd_command("r7_command", 6'd8, {1'b0, 7'($urandom), $urandom}, 40);
    // A following R1 must leave no trace of the R7 reply
    sd_command("r7_then_r1", 6'd0, 40'h01, 8);
    test_display();
    test_contention("contention_first", 1'b1);
    test_contention("contention_repeat", 1'b0);

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
common/spi_periph_pkg.sv
sdcard/sd_cmd_ctrl.sv
lcd/lcd_byte_writer.sv
hw/spi_arbiter.sv
hw/spi_periph_top.sv
sim/spi_arbiter_sva.sv
sim/tb_spi_periph.sv

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_spi_periph \
  -f sources.f -o tb_sim || { echo "build failed"; exit 1; }
out="$(./obj_dir/tb_sim 2>&1)"
echo "$out"
echo "$out" | grep -qF "TEST RESULT: PASS" && exit 0 || exit 1
